//--- Makefile
VERILATOR ?= verilator
TOP       ?= car_tb
FILELIST  ?= car_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- car_ctrl.f
hdl/car_pkg.sv
hdl/input_filter.sv
hdl/line_tracker.sv
hdl/sonar_ranger.sv
hdl/drive_mixer.sv
hdl/pwm_gen.sv
hdl/car_top.sv
verification/car_tb.sv

//--- hdl/car_pkg.sv
`default_nettype none

package car_pkg;

    // Floor sensors, 1 when the line is seen
    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } sensor_t;

    typedef enum logic [2:0] {
        STEER_STRAIGHT,
        STEER_SOFT_R,
        STEER_HARD_R,
        STEER_SOFT_L,
        STEER_HARD_L,
        STEER_SPIN_L,
        STEER_SPIN_R
    } steer_e;

    typedef enum logic [1:0] {
        TRK_FOLLOW,
        TRK_SEARCH_L,
        TRK_SEARCH_R
    } track_state_e;

    typedef enum logic [1:0] {
        SON_IDLE,
        SON_TIMING,
        SON_LATCH
    } sonar_state_e;

    // Full scale is 1024
    typedef logic [9:0] duty_t;

    typedef logic [1:0] hbridge_t;

    localparam hbridge_t HB_FWD   = 2'b10;
    localparam hbridge_t HB_REV   = 2'b01;
    localparam hbridge_t HB_COAST = 2'b00;

    typedef struct packed {
        duty_t    left_duty;
        duty_t    right_duty;
        hbridge_t left_dir;
        hbridge_t right_dir;
    } motor_cmd_t;

    // Echo width in clk cycles, saturates
    typedef logic [19:0] echo_cnt_t;

    localparam duty_t DUTY_FULL = 10'd1023;
    localparam duty_t DUTY_SOFT = 10'd700;
    localparam duty_t DUTY_HARD = 10'd600;

endpackage

`default_nettype wire

//--- hdl/car_top.sv
`timescale 1ns/1ps
`default_nettype none

module car_top #(
    parameter int DEBOUNCE_LEN = 16,
    parameter int PWM_PERIOD   = 4000,
    parameter int TRIG_PERIOD  = 10_000_000,
    parameter int TRIG_WIDTH   = 1000,
    parameter int STOP_CYCLES  = 232_000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              echo,
    input  logic              line_l,
    input  logic              line_m,
    input  logic              line_r,
    input  logic              stop_btn,
    output logic              trig,
    output logic              pwm_l,
    output logic              pwm_r,
    output car_pkg::hbridge_t dir_l,
    output car_pkg::hbridge_t dir_r,
    output logic              led_l,
    output logic              led_m,
    output logic              led_r
);

    import car_pkg::*;

    sensor_t    sensors;
    logic       stop;
    logic       obstacle;
    steer_e     steer;
    motor_cmd_t cmd;

    input_filter #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_filter (
        .clk, .rst, .line_l, .line_m, .line_r, .stop_btn, .sensors, .stop
    );

    line_tracker i_tracker (.clk, .rst, .sensors, .steer);

    sonar_ranger #(
        .TRIG_PERIOD(TRIG_PERIOD),
        .TRIG_WIDTH (TRIG_WIDTH),
        .STOP_CYCLES(STOP_CYCLES)
    ) i_ranger (.clk, .rst, .echo, .trig, .obstacle);

    drive_mixer i_mixer (.clk, .rst, .steer, .stop, .obstacle, .cmd);

    pwm_gen #(.PWM_PERIOD(PWM_PERIOD)) i_pwm_l (.clk, .rst, .duty(cmd.left_duty), .pwm(pwm_l));
    pwm_gen #(.PWM_PERIOD(PWM_PERIOD)) i_pwm_r (.clk, .rst, .duty(cmd.right_duty), .pwm(pwm_r));

    assign dir_l = cmd.left_dir;
    assign dir_r = cmd.right_dir;

    // LEDs show the filtered sensors
    assign led_l = sensors.left;
    assign led_m = sensors.mid;
    assign led_r = sensors.right;

endmodule

`default_nettype wire

//--- hdl/drive_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module drive_mixer (
    input  logic                clk,
    input  logic                rst,
    input  car_pkg::steer_e     steer,
    input  logic                stop,
    input  logic                obstacle,
    output car_pkg::motor_cmd_t cmd
);

    import car_pkg::*;

    motor_cmd_t cmd_next;

    always_comb begin
        cmd_next.left_duty  = DUTY_FULL;
        cmd_next.right_duty = DUTY_FULL;
        cmd_next.left_dir   = HB_FWD;
        cmd_next.right_dir  = HB_FWD;

        case (steer)
            STEER_SOFT_R: cmd_next.right_duty = DUTY_SOFT;
            STEER_HARD_R: cmd_next.right_duty = DUTY_HARD;
            STEER_SOFT_L: cmd_next.left_duty  = DUTY_SOFT;
            STEER_HARD_L: cmd_next.left_duty  = DUTY_HARD;
            STEER_SPIN_L: cmd_next.left_dir   = HB_REV;
            STEER_SPIN_R: cmd_next.right_dir  = HB_REV;
            default: ;
        endcase

        // Halt overrides steering
        if (stop || obstacle) begin
            cmd_next.left_duty  = '0;
            cmd_next.right_duty = '0;
            cmd_next.left_dir   = HB_COAST;
            cmd_next.right_dir  = HB_COAST;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd <= '{left_duty: '0, right_duty: '0, left_dir: HB_COAST, right_dir: HB_COAST};
        end else begin
            cmd <= cmd_next;
        end
    end

    a_no_drive_on_coast: assert property (
        @(posedge clk) disable iff (rst)
        ((cmd.left_dir == HB_COAST) |-> (cmd.left_duty == '0)) and
        ((cmd.right_dir == HB_COAST) |-> (cmd.right_duty == '0))
    ) else $error("drive_mixer: duty with coast direction");

endmodule

`default_nettype wire

//--- hdl/input_filter.sv
`timescale 1ns/1ps
`default_nettype none

module input_filter #(
    parameter int DEBOUNCE_LEN = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              line_l,
    input  logic              line_m,
    input  logic              line_r,
    input  logic              stop_btn,
    output car_pkg::sensor_t  sensors,
    output logic              stop
);

    import car_pkg::*;

    localparam int NUM_IN = 4;

    logic [NUM_IN-1:0]       raw;
    logic [NUM_IN-1:0]       sync1;
    logic [NUM_IN-1:0]       sync2;
    logic [NUM_IN-1:0]       filt;
    logic [DEBOUNCE_LEN-1:0] win [NUM_IN];

    assign raw = {line_l, line_m, line_r, stop_btn};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
        end
    end

    // Output only high after DEBOUNCE_LEN high samples in a row
    for (genvar i = 0; i < NUM_IN; i++) begin : g_filt
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                win[i] <= '0;
            end else begin
                win[i] <= (win[i] << 1) | DEBOUNCE_LEN'(sync2[i]);
            end
        end

        assign filt[i] = &win[i];
    end

    assign sensors = '{left: filt[3], mid: filt[2], right: filt[1]};
    assign stop    = filt[0];

endmodule

`default_nettype wire

//--- hdl/line_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module line_tracker (
    input  logic              clk,
    input  logic              rst,
    input  car_pkg::sensor_t  sensors,
    output car_pkg::steer_e   steer
);

    import car_pkg::*;

    track_state_e state;
    track_state_e state_next;
    steer_e       steer_next;
    logic         last_right;
    logic         last_right_next;
    logic [2:0]   pattern;

    // Bit order is left, mid, right
    assign pattern = sensors;

    always_comb begin
        state_next      = state;
        steer_next      = STEER_STRAIGHT;
        last_right_next = last_right;

        case (state)
            TRK_FOLLOW: begin
                case (pattern)
                    3'b011: begin
                        steer_next      = STEER_SOFT_R;
                        last_right_next = 1'b1;
                    end
                    3'b001: begin
                        steer_next      = STEER_HARD_R;
                        last_right_next = 1'b1;
                    end
                    3'b110: begin
                        steer_next      = STEER_SOFT_L;
                        last_right_next = 1'b0;
                    end
                    3'b100: begin
                        steer_next      = STEER_HARD_L;
                        last_right_next = 1'b0;
                    end
                    3'b000: begin
                        // Line lost, spin toward the last turn
                        state_next = last_right ? TRK_SEARCH_R : TRK_SEARCH_L;
                        steer_next = last_right ? STEER_SPIN_R : STEER_SPIN_L;
                    end
                    default: steer_next = STEER_STRAIGHT;
                endcase
            end
            TRK_SEARCH_L, TRK_SEARCH_R: begin
                if (pattern == 3'b111) begin
                    state_next = TRK_FOLLOW;
                    steer_next = STEER_STRAIGHT;
                end else begin
                    steer_next = (state == TRK_SEARCH_R) ? STEER_SPIN_R : STEER_SPIN_L;
                end
            end
            default: state_next = TRK_FOLLOW;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= TRK_FOLLOW;
            steer      <= STEER_STRAIGHT;
            last_right <= 1'b0;
        end else begin
            state      <= state_next;
            steer      <= steer_next;
            last_right <= last_right_next;
        end
    end

    a_no_spin_in_follow: assert property (
        @(posedge clk) disable iff (rst)
        (state == TRK_FOLLOW) |-> !(steer inside {STEER_SPIN_L, STEER_SPIN_R})
    ) else $error("line_tracker: spin while following");

endmodule

`default_nettype wire

//--- hdl/pwm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_gen #(
    parameter int PWM_PERIOD = 4000
) (
    input  logic           clk,
    input  logic           rst,
    input  car_pkg::duty_t duty,
    output logic           pwm
);

    import car_pkg::*;

    localparam int CNT_W = $clog2(PWM_PERIOD);

    logic [CNT_W-1:0]  cnt;
    logic [CNT_W-1:0]  cnt_next;
    logic [CNT_W-1:0]  high_time;
    logic [CNT_W-1:0]  high_calc;
    logic [CNT_W+9:0]  product;
    logic              period_end;

    // duty * PWM_PERIOD / 1024, rounded down
    assign product    = (CNT_W + 10)'(duty) * (CNT_W + 10)'(PWM_PERIOD);
    assign high_calc  = product[CNT_W+9:10];
    assign period_end = (cnt == CNT_W'(PWM_PERIOD - 1));
    assign cnt_next   = cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            high_time <= '0;
            pwm       <= 1'b0;
        end else if (period_end) begin
            // New period, take the duty now
            cnt       <= '0;
            high_time <= high_calc;
            pwm       <= (high_calc != '0);
        end else begin
            cnt <= cnt_next;
            pwm <= (cnt_next < high_time);
        end
    end

endmodule

`default_nettype wire

//--- hdl/sonar_ranger.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_ranger #(
    parameter int TRIG_PERIOD = 10_000_000,
    parameter int TRIG_WIDTH  = 1000,
    parameter int STOP_CYCLES = 232_000
) (
    input  logic clk,
    input  logic rst,
    input  logic echo,
    output logic trig,
    output logic obstacle
);

    import car_pkg::*;

    localparam int TRIG_CNT_W = $clog2(TRIG_PERIOD);

    logic [TRIG_CNT_W-1:0] trig_cnt;
    logic                  echo_s1;
    logic                  echo_s2;
    logic                  echo_d;
    logic                  echo_rise;
    logic                  echo_fall;
    sonar_state_e          state;
    echo_cnt_t             width;

    // Trigger pulse generator
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_cnt <= '0;
            trig     <= 1'b0;
        end else begin
            if (trig_cnt == TRIG_CNT_W'(TRIG_PERIOD - 1)) begin
                trig_cnt <= '0;
                trig     <= 1'b1;
            end else begin
                trig_cnt <= trig_cnt + 1'b1;
                if (trig_cnt == TRIG_CNT_W'(TRIG_WIDTH - 1)) begin
                    trig <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            echo_s1 <= 1'b0;
            echo_s2 <= 1'b0;
            echo_d  <= 1'b0;
        end else begin
            echo_s1 <= echo;
            echo_s2 <= echo_s1;
            echo_d  <= echo_s2;
        end
    end

    assign echo_rise = echo_s2 & ~echo_d;
    assign echo_fall = ~echo_s2 & echo_d;

    // Echo width timer, counts high cycles of the synchronized echo
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SON_IDLE;
            width    <= '0;
            obstacle <= 1'b0;
        end else begin
            case (state)
                SON_IDLE: begin
                    if (echo_rise) begin
                        width <= echo_cnt_t'(1);
                        state <= SON_TIMING;
                    end
                end
                SON_TIMING: begin
                    if (echo_fall) begin
                        state <= SON_LATCH;
                    end else if (width != '1) begin
                        width <= width + 1'b1;
                    end
                end
                SON_LATCH: begin
                    obstacle <= (width < echo_cnt_t'(STOP_CYCLES));
                    state    <= SON_IDLE;
                end
                default: state <= SON_IDLE;
            endcase
        end
    end

    a_trig_width: assert property (
        @(posedge clk) disable iff (rst)
        $rose(trig) |-> ##TRIG_WIDTH !trig
    ) else $error("sonar_ranger: trig high too long");

endmodule

`default_nettype wire

//--- verification/car_tb.sv
`timescale 1ns/1ps
`default_nettype none

module car_tb;

    import car_pkg::*;

    localparam int DEBOUNCE_LEN = 4;
    localparam int PWM_PERIOD   = 64;
    localparam int TRIG_PERIOD  = 2000;
    localparam int TRIG_WIDTH   = 10;
    localparam int STOP_CYCLES  = 300;

    logic     clk;
    logic     rst;
    logic     echo;
    logic     line_l;
    logic     line_m;
    logic     line_r;
    logic     stop_btn;
    logic     trig;
    logic     pwm_l;
    logic     pwm_r;
    hbridge_t dir_l;
    hbridge_t dir_r;
    logic     led_l;
    logic     led_m;
    logic     led_r;

    int           mismatches = 0;
    int           timeouts = 0;
    track_state_e m_state;
    logic         m_last_right;
    steer_e       m_steer;
    logic [2:0]   cur_pattern;

    car_top #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN),
        .PWM_PERIOD  (PWM_PERIOD),
        .TRIG_PERIOD (TRIG_PERIOD),
        .TRIG_WIDTH  (TRIG_WIDTH),
        .STOP_CYCLES (STOP_CYCLES)
    ) i_dut (.*);

    always #20 clk = ~clk;

    a_reset_quiet: assert property (
        @(negedge clk) rst |-> (!trig && !pwm_l && !pwm_r && dir_l == 2'b00 && dir_r == 2'b00)
    ) else begin
        mismatches++;
        $display("MISMATCH reset: expected trig=0 pwm=00 dir=00/00, actual %b %b%b %b/%b",
                 trig, pwm_l, pwm_r, dir_l, dir_r);
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Tracker rules for one filtered pattern
    task automatic model_step(input logic [2:0] p);
        if (m_state != TRK_FOLLOW) begin
            if (p == 3'b111) begin
                m_state = TRK_FOLLOW;
                m_steer = STEER_STRAIGHT;
            end
        end else begin
            case (p)
                3'b000: begin
                    m_state = m_last_right ? TRK_SEARCH_R : TRK_SEARCH_L;
                    m_steer = m_last_right ? STEER_SPIN_R : STEER_SPIN_L;
                end
                3'b011:  m_steer = STEER_SOFT_R;
                3'b001:  m_steer = STEER_HARD_R;
                3'b110:  m_steer = STEER_SOFT_L;
                3'b100:  m_steer = STEER_HARD_L;
                default: m_steer = STEER_STRAIGHT;
            endcase
            if (m_steer inside {STEER_SOFT_R, STEER_HARD_R}) begin
                m_last_right = 1'b1;
            end else if (m_steer inside {STEER_SOFT_L, STEER_HARD_L}) begin
                m_last_right = 1'b0;
            end
        end
    endtask

    // Duty left, duty right, dir left, dir right
    function automatic motor_cmd_t table_cmd(input steer_e s);
        motor_cmd_t c;
        case (s)
            STEER_SOFT_R: c = '{DUTY_FULL, DUTY_SOFT, 2'b10, 2'b10};
            STEER_HARD_R: c = '{DUTY_FULL, DUTY_HARD, 2'b10, 2'b10};
            STEER_SOFT_L: c = '{DUTY_SOFT, DUTY_FULL, 2'b10, 2'b10};
            STEER_HARD_L: c = '{DUTY_HARD, DUTY_FULL, 2'b10, 2'b10};
            STEER_SPIN_L: c = '{DUTY_FULL, DUTY_FULL, 2'b01, 2'b10};
            STEER_SPIN_R: c = '{DUTY_FULL, DUTY_FULL, 2'b10, 2'b01};
            default:      c = '{DUTY_FULL, DUTY_FULL, 2'b10, 2'b10};
        endcase
        return c;
    endfunction

    function automatic int high_cycles(input duty_t d);
        return (int'(d) * PWM_PERIOD) / 1024;
    endfunction

    // Falling bits settle before raised ones and the tracker sees old & new first
    task automatic apply_pattern(input logic [2:0] p);
        int n;
        int exp_n;
        n = 0;
        @(posedge clk);
        line_l <= p[2];
        line_m <= p[1];
        line_r <= p[0];
        model_step(cur_pattern & p);
        model_step(p);
        // Raised bits wait for the full window after the synchronizer
        if ((p & ~cur_pattern) != 3'b000) begin
            exp_n = 2 + DEBOUNCE_LEN;
        end else if (p != cur_pattern) begin
            exp_n = 3;
        end else begin
            exp_n = 0;
        end
        cur_pattern = p;
        @(negedge clk);
        while ({led_l, led_m, led_r} != p && n < 20) begin
            @(negedge clk);
            n++;
        end
        if ({led_l, led_m, led_r} != p) begin
            timeouts++;
            $display("Timeout: LEDs never showed sensor pattern %b", p);
        end
        check_value($sformatf("led latency %b", p), exp_n, n);
        // Tracker and mixer stages
        repeat (2) @(negedge clk);
    endtask

    task automatic check_drive(input string name, input logic halted);
        motor_cmd_t c;
        int         high_l;
        int         high_r;
        if (halted) begin
            c = '0;
        end else begin
            c = table_cmd(m_steer);
        end
        high_l = 0;
        high_r = 0;
        check_value({name, " leds"}, int'(cur_pattern), int'({led_l, led_m, led_r}));
        check_value({name, " dir_l"}, int'(c.left_dir), int'(dir_l));
        check_value({name, " dir_r"}, int'(c.right_dir), int'(dir_r));
        // Let the running period finish before counting a full one
        repeat (PWM_PERIOD) @(negedge clk);
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            high_l += int'(pwm_l);
            high_r += int'(pwm_r);
        end
        check_value({name, " pwm_l high"}, high_cycles(c.left_duty), high_l);
        check_value({name, " pwm_r high"}, high_cycles(c.right_duty), high_r);
    endtask

    task automatic wait_coast(input logic want, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while ((dir_l == 2'b00) != want && n < 100) begin
            @(negedge clk);
            n++;
        end
        if ((dir_l == 2'b00) != want) begin
            timeouts++;
            $display("Timeout: %s, left wheel direction did not change", name);
        end
    endtask

    task automatic count_trig_level(input logic level, output int n);
        n = 0;
        while (trig == level && n < TRIG_PERIOD + 10) begin
            @(negedge clk);
            n++;
        end
        if (trig == level) begin
            timeouts++;
            $display("Timeout: trig stayed at %b for too long", level);
        end
    endtask

    task automatic echo_pulse(input int len);
        @(posedge clk);
        echo <= 1'b1;
        repeat (len) @(posedge clk);
        echo <= 1'b0;
    endtask

    task automatic check_search(input string side, input logic [2:0] turn,
                                input hbridge_t exp_l, input hbridge_t exp_r);
        apply_pattern(3'b111);
        apply_pattern(turn);
        check_drive({side, " turn"}, 1'b0);
        apply_pattern(3'b000);
        check_value({side, " lost dir_l"}, int'(exp_l), int'(dir_l));
        check_value({side, " lost dir_r"}, int'(exp_r), int'(dir_r));
        check_drive({side, " lost"}, 1'b0);
        apply_pattern(3'b010);
        check_drive({side, " hold 010"}, 1'b0);
        apply_pattern(3'b101);
        check_drive({side, " hold 101"}, 1'b0);
        apply_pattern(3'b011);
        check_drive({side, " hold 011"}, 1'b0);
        apply_pattern(3'b111);
        check_drive({side, " found"}, 1'b0);
    endtask

    initial begin
        logic [2:0] p;
        int         n_first;
        int         n_high;
        int         n_low;
        int         n;
        void'($urandom(32'h4354_857e));
        clk          = 1'b0;
        rst          = 1'b1;
        echo         = 1'b0;
        line_l       = 1'b0;
        line_m       = 1'b0;
        line_r       = 1'b0;
        stop_btn     = 1'b0;
        m_state      = TRK_FOLLOW;
        m_last_right = 1'b0;
        m_steer      = STEER_STRAIGHT;
        cur_pattern  = 3'b000;
        // Blank floor from the start
        model_step(3'b000);

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("after reset trig", 0, int'(trig));
        check_value("after reset pwm", 0, int'({pwm_l, pwm_r}));
        check_value("after reset dir_l", 0, int'(dir_l));
        check_value("after reset dir_r", 0, int'(dir_r));

        count_trig_level(1'b0, n_first);
        count_trig_level(1'b1, n_high);
        count_trig_level(1'b0, n_low);
        check_value("trig first rise", TRIG_PERIOD, n_first);
        check_value("trig width", TRIG_WIDTH, n_high);
        check_value("trig interval", TRIG_PERIOD, n_high + n_low);

        apply_pattern(3'b111);
        check_drive("table start", 1'b0);
        for (int i = 0; i < 16; i++) begin
            p = 3'($urandom);
            apply_pattern(p);
            check_drive($sformatf("table %0d pattern %b", i, p), 1'b0);
        end

        check_search("search right", 3'b001, 2'b10, 2'b01);
        check_search("search left", 3'b100, 2'b01, 2'b10);

        apply_pattern(3'b010);
        echo_pulse(STOP_CYCLES / 3);
        wait_coast(1'b1, "obstacle halt");
        check_drive("obstacle near", 1'b1);
        echo_pulse(STOP_CYCLES + 100);
        wait_coast(1'b0, "obstacle clear");
        check_drive("obstacle far", 1'b0);

        // Button glitch one cycle short of the filter window
        @(posedge clk);
        stop_btn <= 1'b1;
        repeat (DEBOUNCE_LEN - 1) @(posedge clk);
        stop_btn <= 1'b0;
        n = 0;
        repeat (20) begin
            @(negedge clk);
            n += int'(dir_l == 2'b00);
        end
        check_value("stop glitch coast cycles", 0, n);
        check_drive("stop glitch", 1'b0);
        @(posedge clk);
        stop_btn <= 1'b1;
        wait_coast(1'b1, "stop halt");
        check_drive("stop held", 1'b1);
        @(posedge clk);
        stop_btn <= 1'b0;
        wait_coast(1'b0, "stop release");
        check_drive("stop release", 1'b0);

        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
